/* logic/osc_pkg.sv */
/*
 * oscilloscope channel shared definitions
 * sample, counter and bus widths, register map and sequencer states
 */
package osc_pkg;

  // widths
  localparam int SMP_W  = 16;
  localparam int EVN_W  = 4;
  localparam int CNT_W  = 32;
  localparam int DEC_W  = 17;
  localparam int SHR_W  = 4;
  localparam int WORD_W = 32;
  localparam int ADDR_W = 7;

  typedef logic signed [SMP_W-1:0]     sample_t;
  typedef logic        [EVN_W-1:0]     evn_t;
  typedef logic        [CNT_W-1:0]     cnt_t;
  typedef logic        [DEC_W-1:0]     dec_t;
  typedef logic        [SHR_W-1:0]     shr_t;
  // group sum, one extra bit of headroom
  typedef logic signed [SMP_W+DEC_W:0] acc_t;
  typedef logic        [WORD_W-1:0]    word_t;
  typedef logic        [ADDR_W-1:0]    addr_t;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////
  localparam addr_t REG_CTL     = 7'h00;
  localparam addr_t REG_MSK_STR = 7'h04;
  localparam addr_t REG_MSK_STP = 7'h08;
  localparam addr_t REG_MSK_TRG = 7'h0C;
  localparam addr_t REG_CFG_PRE = 7'h10;
  localparam addr_t REG_CFG_PST = 7'h14;
  localparam addr_t REG_STS_PRE = 7'h18;
  localparam addr_t REG_STS_PST = 7'h1C;
  localparam addr_t REG_LVL_POS = 7'h20;
  localparam addr_t REG_LVL_NEG = 7'h24;
  localparam addr_t REG_EDG     = 7'h28;
  localparam addr_t REG_DEC     = 7'h30;
  localparam addr_t REG_SHR     = 7'h34;
  localparam addr_t REG_AVG     = 7'h38;

  // acquisition sequencer states
  typedef enum logic [1:0] {
    ACQ_IDLE,
    ACQ_PRE,
    ACQ_ARMED,
    ACQ_POST
  } acq_state_t;

endpackage

/* logic/osc_regs.sv */
/*
 * oscilloscope register bank
 * bus decode, configuration storage, software event pulses,
 * event mask reduction and status readback
 */
`timescale 1ns/1ps

module osc_regs (
  input  logic                bus,
  input  logic                rst,
  // register bus
  input  logic                wen,
  input  logic                ren,
  input  osc_pkg::addr_t      addr,
  input  osc_pkg::word_t      wdata,
  output osc_pkg::word_t      rdata,
  output logic                ack,
  // events
  input  osc_pkg::evn_t       evn_ext,
  output logic                ctl_rst,
  output logic                evn_str,
  output logic                evn_stp,
  output logic                evn_trg,
  output logic                acq_str,
  output logic                acq_stp,
  output logic                acq_trg,
  // sequencer status
  input  osc_pkg::acq_state_t sts_state,
  input  osc_pkg::cnt_t       sts_pre,
  input  osc_pkg::cnt_t       sts_pst,
  // configuration
  output osc_pkg::cnt_t       cfg_pre,
  output osc_pkg::cnt_t       cfg_pst,
  output osc_pkg::sample_t    cfg_pos,
  output osc_pkg::sample_t    cfg_neg,
  output logic                cfg_edg,
  output osc_pkg::dec_t       cfg_dec,
  output osc_pkg::shr_t       cfg_shr,
  output logic                cfg_avg
);

  import osc_pkg::*;

  // event select masks
  evn_t  msk_str;
  evn_t  msk_stp;
  evn_t  msk_trg;
  word_t rd_val;

  ////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////

  // one cycle response to any access
  always_ff @(posedge bus) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= wen | ren;
    end
  end

  // configuration writes
  always_ff @(posedge bus) begin
    if (rst) begin
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
      cfg_pre <= '0;
      cfg_pst <= '0;
      cfg_pos <= '0;
      cfg_neg <= '0;
      cfg_edg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
      cfg_avg <= 1'b0;
    end else if (wen) begin
      case (addr)
        REG_MSK_STR: msk_str <= wdata[EVN_W-1:0];
        REG_MSK_STP: msk_stp <= wdata[EVN_W-1:0];
        REG_MSK_TRG: msk_trg <= wdata[EVN_W-1:0];
        REG_CFG_PRE: cfg_pre <= wdata;
        REG_CFG_PST: cfg_pst <= wdata;
        REG_LVL_POS: cfg_pos <= wdata[SMP_W-1:0];
        REG_LVL_NEG: cfg_neg <= wdata[SMP_W-1:0];
        REG_EDG:     cfg_edg <= wdata[0];
        REG_DEC:     cfg_dec <= wdata[DEC_W-1:0];
        REG_SHR:     cfg_shr <= wdata[SHR_W-1:0];
        REG_AVG:     cfg_avg <= wdata[0];
        default:     ;
      endcase
    end
  end

  // control register pulses, low unless written this cycle
  always_ff @(posedge bus) begin
    if (rst) begin
      ctl_rst <= 1'b0;
      evn_str <= 1'b0;
      evn_stp <= 1'b0;
      evn_trg <= 1'b0;
    end else begin
      ctl_rst <= wen && (addr == REG_CTL) && wdata[0];
      evn_str <= wen && (addr == REG_CTL) && wdata[1];
      evn_stp <= wen && (addr == REG_CTL) && wdata[2];
      evn_trg <= wen && (addr == REG_CTL) && wdata[3];
    end
  end

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////

  // unmapped offsets read as zero
  always_comb begin
    rd_val = '0;
    case (addr)
      REG_CTL: begin
        rd_val[1] = (sts_state != ACQ_IDLE);
        rd_val[2] = (sts_state == ACQ_ARMED);
        rd_val[3] = (sts_state == ACQ_POST);
      end
      REG_MSK_STR: rd_val[EVN_W-1:0] = msk_str;
      REG_MSK_STP: rd_val[EVN_W-1:0] = msk_stp;
      REG_MSK_TRG: rd_val[EVN_W-1:0] = msk_trg;
      REG_CFG_PRE: rd_val = cfg_pre;
      REG_CFG_PST: rd_val = cfg_pst;
      REG_STS_PRE: rd_val = sts_pre;
      REG_STS_PST: rd_val = sts_pst;
      // levels read back zero extended
      REG_LVL_POS: rd_val[SMP_W-1:0] = cfg_pos;
      REG_LVL_NEG: rd_val[SMP_W-1:0] = cfg_neg;
      REG_EDG:     rd_val[0] = cfg_edg;
      REG_DEC:     rd_val[DEC_W-1:0] = cfg_dec;
      REG_SHR:     rd_val[SHR_W-1:0] = cfg_shr;
      REG_AVG:     rd_val[0] = cfg_avg;
      default:     rd_val = '0;
    endcase
  end

  // read data lines up with ack
  always_ff @(posedge bus) begin
    if (ren) begin
      rdata <= rd_val;
    end
  end

  // masked external events into the sequencer
  assign acq_str = |(evn_ext & msk_str);
  assign acq_stp = |(evn_ext & msk_stp);
  assign acq_trg = |(evn_ext & msk_trg);

endmodule

/* logic/osc_decimator.sv */
/*
 * sample decimator
 * keeps one sample per group of cfg_dec+1, either the last one
 * or the group sum shifted right by cfg_shr
 */
`timescale 1ns/1ps

module osc_decimator (
  input  logic             bus,
  input  logic             rst,
  input  logic             ctl_rst,
  // configuration
  input  logic             cfg_avg,
  input  osc_pkg::dec_t    cfg_dec,
  input  osc_pkg::shr_t    cfg_shr,
  // input stream
  input  osc_pkg::sample_t sti_data,
  input  logic             sti_valid,
  // output stream
  output osc_pkg::sample_t dec_data,
  output logic             dec_valid
);

  import osc_pkg::*;

  dec_t cnt;
  acc_t acc;
  acc_t acc_sum;
  acc_t avg;
  logic grp_end;

  // first sample of a group restarts the sum
  assign acc_sum = (cnt == '0) ? acc_t'(sti_data) : acc + acc_t'(sti_data);
  // arithmetic shift keeps the sign
  assign avg     = acc_sum >>> cfg_shr;
  // also closes a group if the factor was lowered mid group
  assign grp_end = sti_valid && (cnt >= cfg_dec);

  // group counter
  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      cnt       <= '0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= grp_end;
      if (sti_valid) begin
        cnt <= grp_end ? '0 : cnt + 1'b1;
      end
    end
  end

  // running sum and output sample
  always_ff @(posedge bus) begin
    if (sti_valid) begin
      acc <= acc_sum;
    end
    if (grp_end) begin
      dec_data <= cfg_avg ? avg[SMP_W-1:0] : sti_data;
    end
  end

endmodule

/* logic/osc_edge_trigger.sv */
/*
 * level trigger with hysteresis
 * arms beyond one level, fires on crossing the other,
 * samples pass through with one cycle delay
 */
`timescale 1ns/1ps

module osc_edge_trigger (
  input  logic             bus,
  input  logic             rst,
  input  logic             ctl_rst,
  // configuration
  input  logic             cfg_edg,
  input  osc_pkg::sample_t cfg_pos,
  input  osc_pkg::sample_t cfg_neg,
  // input stream
  input  osc_pkg::sample_t dec_data,
  input  logic             dec_valid,
  // output stream and trigger
  output osc_pkg::sample_t edg_data,
  output logic             edg_valid,
  output logic             evn_lvl
);

  logic armed;
  logic lvl_lo;
  logic lvl_hi;
  logic arm_hit;
  logic fire_hit;

  // signed level compares
  assign lvl_lo   = (dec_data <= cfg_neg);
  assign lvl_hi   = (dec_data >= cfg_pos);
  // falling edge swaps the roles
  assign arm_hit  = cfg_edg ? lvl_hi : lvl_lo;
  assign fire_hit = cfg_edg ? lvl_lo : lvl_hi;

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      armed     <= 1'b0;
      edg_valid <= 1'b0;
      evn_lvl   <= 1'b0;
    end else begin
      edg_valid <= dec_valid;
      evn_lvl   <= 1'b0;
      if (dec_valid) begin
        if (armed && fire_hit) begin
          // pulse with this sample, wait for re-arm
          evn_lvl <= 1'b1;
          armed   <= 1'b0;
        end else if (arm_hit) begin
          armed <= 1'b1;
        end
      end
    end
  end

  // data path delay matches valid
  always_ff @(posedge bus) begin
    edg_data <= dec_data;
  end

endmodule

/* logic/osc_acquire.sv */
/*
 * acquisition sequencer
 * pre-trigger fill, armed wait, post-trigger window,
 * frames one record per start on the output stream
 */
`timescale 1ns/1ps

module osc_acquire (
  input  logic                bus,
  input  logic                rst,
  input  logic                ctl_rst,
  // acquisition controls
  input  logic                acq_str,
  input  logic                acq_stp,
  input  logic                acq_trg,
  // configuration
  input  osc_pkg::cnt_t       cfg_pre,
  input  osc_pkg::cnt_t       cfg_pst,
  // input stream
  input  osc_pkg::sample_t    edg_data,
  input  logic                edg_valid,
  // output stream
  output osc_pkg::sample_t    sto_data,
  output logic                sto_valid,
  output logic                sto_last,
  // status
  output osc_pkg::acq_state_t sts_state,
  output osc_pkg::cnt_t       sts_pre,
  output osc_pkg::cnt_t       sts_pst
);

  import osc_pkg::*;

  acq_state_t state;
  cnt_t       pre_nxt;
  cnt_t       pst_nxt;
  logic       pst_end;

  // pre count saturates at cfg_pre
  assign pre_nxt = (edg_valid && sts_pre != cfg_pre) ? sts_pre + 1'b1 : sts_pre;
  assign pst_nxt = edg_valid ? sts_pst + 1'b1 : sts_pst;
  // sample that completes the post window
  assign pst_end = edg_valid && (pst_nxt == cfg_pst);

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////
  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      state   <= ACQ_IDLE;
      sts_pre <= '0;
      sts_pst <= '0;
    end else if (acq_stp) begin
      // stop wins in any state
      state <= ACQ_IDLE;
    end else begin
      case (state)
        ACQ_IDLE: begin
          if (acq_str) begin
            state   <= ACQ_PRE;
            sts_pre <= '0;
            sts_pst <= '0;
          end
        end
        ACQ_PRE: begin
          // triggers ignored until the pre count is met
          sts_pre <= pre_nxt;
          if (pre_nxt == cfg_pre) begin
            state <= ACQ_ARMED;
          end
        end
        ACQ_ARMED: begin
          sts_pre <= pre_nxt;
          if (acq_trg) begin
            state <= ACQ_POST;
          end
        end
        ACQ_POST: begin
          sts_pst <= pst_nxt;
          if (pst_end) begin
            state <= ACQ_IDLE;
          end
        end
        default: state <= ACQ_IDLE;
      endcase
    end
  end

  // output framing, forwarded only outside idle
  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      sto_valid <= 1'b0;
      sto_last  <= 1'b0;
    end else begin
      sto_valid <= edg_valid && (state != ACQ_IDLE);
      sto_last  <= pst_end && (state == ACQ_POST) && !acq_stp;
    end
  end

  always_ff @(posedge bus) begin
    sto_data <= edg_data;
  end

  assign sts_state = state;

endmodule

/* logic/osc_top.sv */
/*
 * oscilloscope channel top level
 * register bank, decimator, level trigger and acquisition sequencer
 */
`timescale 1ns/1ps

module osc_top (
  input  logic             bus,
  input  logic             rst,
  // register bus
  input  logic             wen,
  input  logic             ren,
  input  osc_pkg::addr_t   addr,
  input  osc_pkg::word_t   wdata,
  output osc_pkg::word_t   rdata,
  output logic             ack,
  // sample streams
  input  osc_pkg::sample_t sti_data,
  input  logic             sti_valid,
  output osc_pkg::sample_t sto_data,
  output logic             sto_valid,
  output logic             sto_last,
  // events
  input  osc_pkg::evn_t    evn_ext,
  output logic             evn_str,
  output logic             evn_stp,
  output logic             evn_trg,
  output logic             evn_lvl,
  output logic             evn_lst
);

  import osc_pkg::*;

  // control
  logic       ctl_rst;
  logic       acq_str;
  logic       acq_stp;
  logic       acq_trg;
  // configuration
  cnt_t       cfg_pre;
  cnt_t       cfg_pst;
  sample_t    cfg_pos;
  sample_t    cfg_neg;
  logic       cfg_edg;
  dec_t       cfg_dec;
  shr_t       cfg_shr;
  logic       cfg_avg;
  // internal streams
  sample_t    dec_data;
  logic       dec_valid;
  sample_t    edg_data;
  logic       edg_valid;
  // status
  acq_state_t sts_state;
  cnt_t       sts_pre;
  cnt_t       sts_pst;

  ////////////////////////////////////////
  // register bank
  ////////////////////////////////////////
  osc_regs i_osc_regs (
    .bus       (bus),
    .rst       (rst),
    .wen       (wen),
    .ren       (ren),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata),
    .ack       (ack),
    .evn_ext   (evn_ext),
    .ctl_rst   (ctl_rst),
    .evn_str   (evn_str),
    .evn_stp   (evn_stp),
    .evn_trg   (evn_trg),
    .acq_str   (acq_str),
    .acq_stp   (acq_stp),
    .acq_trg   (acq_trg),
    .sts_state (sts_state),
    .sts_pre   (sts_pre),
    .sts_pst   (sts_pst),
    .cfg_pre   (cfg_pre),
    .cfg_pst   (cfg_pst),
    .cfg_pos   (cfg_pos),
    .cfg_neg   (cfg_neg),
    .cfg_edg   (cfg_edg),
    .cfg_dec   (cfg_dec),
    .cfg_shr   (cfg_shr),
    .cfg_avg   (cfg_avg)
  );

  ////////////////////////////////////////
  // sample path
  ////////////////////////////////////////
  osc_decimator i_osc_decimator (
    .bus       (bus),
    .rst       (rst),
    .ctl_rst   (ctl_rst),
    .cfg_avg   (cfg_avg),
    .cfg_dec   (cfg_dec),
    .cfg_shr   (cfg_shr),
    .sti_data  (sti_data),
    .sti_valid (sti_valid),
    .dec_data  (dec_data),
    .dec_valid (dec_valid)
  );

  osc_edge_trigger i_osc_edge_trigger (
    .bus       (bus),
    .rst       (rst),
    .ctl_rst   (ctl_rst),
    .cfg_edg   (cfg_edg),
    .cfg_pos   (cfg_pos),
    .cfg_neg   (cfg_neg),
    .dec_data  (dec_data),
    .dec_valid (dec_valid),
    .edg_data  (edg_data),
    .edg_valid (edg_valid),
    .evn_lvl   (evn_lvl)
  );

  osc_acquire i_osc_acquire (
    .bus       (bus),
    .rst       (rst),
    .ctl_rst   (ctl_rst),
    .acq_str   (acq_str),
    .acq_stp   (acq_stp),
    .acq_trg   (acq_trg),
    .cfg_pre   (cfg_pre),
    .cfg_pst   (cfg_pst),
    .edg_data  (edg_data),
    .edg_valid (edg_valid),
    .sto_data  (sto_data),
    .sto_valid (sto_valid),
    .sto_last  (sto_last),
    .sts_state (sts_state),
    .sts_pre   (sts_pre),
    .sts_pst   (sts_pst)
  );

  // end of record event
  assign evn_lst = sto_last;

endmodule

/* verif/osc_asserts.sv */
/*
 * protocol checks on the oscilloscope top level
 * bus ack timing, stream framing and event pulse width
 */
`timescale 1ns/1ps

module osc_asserts (
  input logic bus,
  input logic rst,
  input logic wen,
  input logic ren,
  input logic ack,
  input logic sto_valid,
  input logic sto_last,
  input logic evn_str
);

  // ack one cycle after each access and never otherwise
  ack_after_access: assert property (@(posedge bus) disable iff (rst) (wen || ren) |=> ack)
    else $error("ack missing one cycle after a bus access");
  ack_without_access: assert property (@(posedge bus) disable iff (rst) !(wen || ren) |=> !ack)
    else $error("ack without a bus access one cycle before");

  // last marks a valid sample
  last_with_valid: assert property (@(posedge bus) disable iff (rst) sto_last |-> sto_valid)
    else $error("sto_last without sto_valid");

  start_one_cycle: assert property (@(posedge bus) disable iff (rst) evn_str |=> !evn_str)
    else $error("evn_str longer than one cycle");

  valid_in_reset: assert property (@(posedge bus) rst |=> !sto_valid)
    else $error("sto_valid high during reset");

endmodule

bind osc_top osc_asserts i_osc_asserts (
  .bus       (bus),
  .rst       (rst),
  .wen       (wen),
  .ren       (ren),
  .ack       (ack),
  .sto_valid (sto_valid),
  .sto_last  (sto_last),
  .evn_str   (evn_str)
);

/* verif/osc_tb.sv */
/*
 * oscilloscope channel testbench
 * directed tests for register access, decimation, averaging,
 * level trigger, pre/post window, stop and soft reset
 */
`timescale 1ns/1ps

module osc_tb;

  import osc_pkg::*;

  localparam int CLK_NS  = 4;
  localparam int LVL_POS = 100;
  localparam int LVL_NEG = -100;
  // cycle budget per test, doubled for the watchdog
  localparam int RUN_CYCLES = 150 + 300 + 300 + 250 + 250 + 300;

  logic    bus;
  logic    rst;
  logic    wen;
  logic    ren;
  addr_t   addr;
  word_t   wdata;
  word_t   rdata;
  logic    ack;
  sample_t sti_data;
  logic    sti_valid;
  sample_t sto_data;
  logic    sto_valid;
  logic    sto_last;
  evn_t    evn_ext;
  logic    evn_str;
  logic    evn_stp;
  logic    evn_trg;
  logic    evn_lvl;
  logic    evn_lst;

  int      checks;
  int      errors;
  word_t   rng;
  // reference model state
  int      m_cnt;
  longint  m_sum;
  int      m_dec;
  int      m_shr;
  bit      m_avg;
  bit      m_armed;
  sample_t exp_q[$];
  sample_t lvl_exp_q[$];
  // observed stream
  sample_t out_q[$];
  logic    last_q[$];
  logic    lst_q[$];
  sample_t lvl_q[$];
  int      lvl_cnt = 0;
  logic    lvl_seen = 1'b0;

  // software and level events come back as external events
  assign evn_ext = {evn_lvl, evn_trg, evn_stp, evn_str};

  osc_top i_osc_top (
    .bus       (bus),
    .rst       (rst),
    .wen       (wen),
    .ren       (ren),
    .addr      (addr),
    .wdata     (wdata),
    .rdata     (rdata),
    .ack       (ack),
    .sti_data  (sti_data),
    .sti_valid (sti_valid),
    .sto_data  (sto_data),
    .sto_valid (sto_valid),
    .sto_last  (sto_last),
    .evn_ext   (evn_ext),
    .evn_str   (evn_str),
    .evn_stp   (evn_stp),
    .evn_trg   (evn_trg),
    .evn_lvl   (evn_lvl),
    .evn_lst   (evn_lst)
  );

  always #(CLK_NS / 2) bus = ~bus;

  // output monitor, sampled away from the active edge
  always @(negedge bus) begin
    if (!rst) begin
      if (sto_valid) begin
        out_q.push_back(sto_data);
        last_q.push_back(sto_last);
        lst_q.push_back(evn_lst);
        // level pulse leads its sample by one stage
        if (lvl_seen) begin
          lvl_q.push_back(sto_data);
        end
      end
      if (evn_lvl) begin
        lvl_cnt++;
      end
      lvl_seen = evn_lvl;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input word_t got, input word_t want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, want);
    end
  endtask

  // ack is due at the first falling edge after the access
  task automatic wait_ack();
    int waited;
    waited = 0;
    while (!ack && waited < 8) begin
      @(negedge bus);
      waited++;
    end
    checks++;
    assert (ack && waited == 0) else begin
      errors++;
      $display("Bus ack did not arrive one cycle after the access, waited %0d cycles", waited);
    end
  endtask

  task automatic bus_write(input addr_t a, input word_t d);
    @(negedge bus);
    wen       = 1'b1;
    addr      = a;
    wdata     = d;
    sti_valid = 1'b0;
    @(negedge bus);
    wen = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input addr_t a, output word_t d);
    @(negedge bus);
    ren       = 1'b1;
    addr      = a;
    sti_valid = 1'b0;
    @(negedge bus);
    ren = 1'b0;
    wait_ack();
    d = rdata;
  endtask

  // group of m_dec+1 samples, then rising level trigger with hysteresis
  task automatic model_sample(input sample_t s);
    sample_t dec_out;
    m_sum = (m_cnt == 0) ? longint'(s) : m_sum + longint'(s);
    if (m_cnt == m_dec) begin
      dec_out = m_avg ? sample_t'(m_sum >>> m_shr) : s;
      exp_q.push_back(dec_out);
      m_cnt = 0;
      if (m_armed && dec_out >= LVL_POS) begin
        lvl_exp_q.push_back(dec_out);
        m_armed = 1'b0;
      end else if (dec_out <= LVL_NEG) begin
        m_armed = 1'b1;
      end
    end else begin
      m_cnt++;
    end
  endtask

  task automatic drive_sample(input sample_t s);
    @(negedge bus);
    sti_data  = s;
    sti_valid = 1'b1;
    model_sample(s);
  endtask

  task automatic drive_gap();
    @(negedge bus);
    sti_valid = 1'b0;
    sti_data  = sample_t'(16'hDEAD);
  endtask

  // valid low until the pipeline is empty
  task automatic flush_pipe();
    @(negedge bus);
    sti_valid = 1'b0;
    repeat (4) @(negedge bus);
  endtask

  task automatic feed_random(input int n);
    int sent;
    sent = 0;
    while (sent < n) begin
      rng = lcg_next(rng);
      if (rng[27]) begin
        drive_gap();
      end
      rng = lcg_next(rng);
      drive_sample(sample_t'(rng[31:16]));
      sent++;
    end
  endtask

  task automatic ramp_to(inout int level, input int target);
    while (level != target) begin
      level += (target > level) ? 25 : -25;
      drive_sample(sample_t'(level));
    end
  endtask

  task automatic clear_queues();
    exp_q.delete();
    lvl_exp_q.delete();
    out_q.delete();
    last_q.delete();
    lst_q.delete();
    lvl_q.delete();
  endtask

  // start on evn_str, stop on evn_stp, trigger on evn_trg
  task automatic setup_channel(input int dec, input bit avg, input int shr,
                               input word_t pre, input word_t pst);
    bus_write(REG_MSK_STR, 32'h1);
    bus_write(REG_MSK_STP, 32'h2);
    bus_write(REG_MSK_TRG, 32'h4);
    bus_write(REG_CFG_PRE, pre);
    bus_write(REG_CFG_PST, pst);
    bus_write(REG_LVL_POS, word_t'(LVL_POS));
    bus_write(REG_LVL_NEG, word_t'(LVL_NEG));
    bus_write(REG_EDG, 32'h0);
    bus_write(REG_DEC, word_t'(dec));
    bus_write(REG_SHR, word_t'(shr));
    bus_write(REG_AVG, word_t'(avg));
    m_dec = dec;
    m_avg = avg;
    m_shr = shr;
  endtask

  task automatic soft_reset();
    bus_write(REG_CTL, 32'h1);
    clear_queues();
    m_cnt   = 0;
    m_sum   = 0;
    m_armed = 1'b0;
  endtask

  task automatic start_acq();
    bus_write(REG_CTL, 32'h2);
  endtask

  task automatic wait_outputs(input int n);
    int k;
    k = 0;
    while (out_q.size() < n && k < 200) begin
      @(negedge bus);
      k++;
    end
    checks++;
    assert (out_q.size() >= n) else begin
      errors++;
      $display("Timed out waiting for %0d output samples, saw %0d", n, out_q.size());
    end
    repeat (4) @(negedge bus);
  endtask

  task automatic compare_stream();
    wait_outputs(exp_q.size());
    check_val("output count", word_t'(out_q.size()), word_t'(exp_q.size()));
    foreach (exp_q[i]) begin
      if (i < out_q.size()) begin
        check_val("sto_data", word_t'(out_q[i]), word_t'(exp_q[i]));
      end
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic regs_readback();
    addr_t regs [11];
    word_t msks [11];
    word_t vals [11];
    word_t got;
    regs = '{REG_MSK_STR, REG_MSK_STP, REG_MSK_TRG, REG_CFG_PRE, REG_CFG_PST,
             REG_LVL_POS, REG_LVL_NEG, REG_EDG, REG_DEC, REG_SHR, REG_AVG};
    msks = '{32'hF, 32'hF, 32'hF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
             32'hFFFF, 32'hFFFF, 32'h1, 32'h1_FFFF, 32'hF, 32'h1};
    for (int i = 0; i < 11; i++) begin
      rng     = lcg_next(rng);
      vals[i] = rng;
      bus_write(regs[i], vals[i]);
    end
    for (int i = 0; i < 11; i++) begin
      bus_read(regs[i], got);
      check_val($sformatf("rdata at %h", regs[i]), got, vals[i] & msks[i]);
    end
    // gaps in the map
    bus_read(7'h2C, got);
    check_val("rdata at 2c", got, 32'h0);
    bus_read(7'h3C, got);
    check_val("rdata at 3c", got, 32'h0);
  endtask

  task automatic decim_plain();
    setup_channel(3, 1'b0, 0, 32'd0, 32'd1000);
    soft_reset();
    start_acq();
    feed_random(40);
    flush_pipe();
    compare_stream();
  endtask

  task automatic decim_average();
    setup_channel(3, 1'b1, 2, 32'd0, 32'd1000);
    soft_reset();
    start_acq();
    feed_random(40);
    flush_pipe();
    compare_stream();
  endtask

  task automatic level_trigger();
    int level;
    int base;
    setup_channel(0, 1'b0, 0, 32'd0, 32'd1000);
    soft_reset();
    start_acq();
    base  = lvl_cnt;
    level = 0;
    // dip and rise, second crossing without a dip, then dip and rise again
    ramp_to(level, -150);
    ramp_to(level, 150);
    ramp_to(level, 50);
    ramp_to(level, 150);
    ramp_to(level, -150);
    ramp_to(level, 150);
    flush_pipe();
    compare_stream();
    check_val("evn_lvl count", word_t'(lvl_cnt - base), 32'd2);
    check_val("evn_lvl count", word_t'(lvl_q.size()), word_t'(lvl_exp_q.size()));
    foreach (lvl_exp_q[i]) begin
      if (i < lvl_q.size()) begin
        check_val("sto_data at evn_lvl", word_t'(lvl_q[i]), word_t'(lvl_exp_q[i]));
      end
    end
  endtask

  task automatic trigger_window();
    word_t got;
    setup_channel(0, 1'b0, 0, 32'd5, 32'd7);
    soft_reset();
    start_acq();
    feed_random(3);
    flush_pipe();
    // early trigger, still filling the pre window
    bus_write(REG_CTL, 32'h8);
    feed_random(4);
    flush_pipe();
    bus_read(REG_STS_PRE, got);
    check_val("sts_pre", got, 32'd5);
    bus_read(REG_CTL, got);
    check_val("status", got, 32'h6);
    clear_queues();
    bus_write(REG_CTL, 32'h8);
    feed_random(12);
    flush_pipe();
    wait_outputs(7);
    check_val("output count", word_t'(out_q.size()), 32'd7);
    foreach (out_q[i]) begin
      check_val("sto_data", word_t'(out_q[i]), word_t'(exp_q[i]));
      check_val("sto_last", word_t'(last_q[i]), word_t'(i == 6));
      // end of record event marks the same sample
      check_val("evn_lst", word_t'(lst_q[i]), word_t'(i == 6));
    end
    bus_read(REG_CTL, got);
    check_val("status", got, 32'h0);
    bus_read(REG_STS_PST, got);
    check_val("sts_pst", got, 32'd7);
  endtask

  task automatic stop_and_reset();
    word_t got;
    setup_channel(0, 1'b0, 0, 32'd0, 32'd100);
    soft_reset();
    start_acq();
    bus_write(REG_CTL, 32'h8);
    feed_random(5);
    flush_pipe();
    // running and triggered before the stop
    bus_read(REG_CTL, got);
    check_val("status", got, 32'hA);
    bus_write(REG_CTL, 32'h4);
    feed_random(5);
    flush_pipe();
    wait_outputs(5);
    check_val("output count", word_t'(out_q.size()), 32'd5);
    foreach (out_q[i]) begin
      check_val("sto_data", word_t'(out_q[i]), word_t'(exp_q[i]));
      check_val("sto_last", word_t'(last_q[i]), 32'h0);
    end
    bus_read(REG_CTL, got);
    check_val("status", got, 32'h0);
    // soft reset in the middle of a group of four
    setup_channel(3, 1'b0, 0, 32'd0, 32'd100);
    soft_reset();
    start_acq();
    feed_random(2);
    flush_pipe();
    soft_reset();
    start_acq();
    feed_random(8);
    flush_pipe();
    compare_stream();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    bus       = 1'b0;
    rst       = 1'b1;
    wen       = 1'b0;
    ren       = 1'b0;
    addr      = '0;
    wdata     = '0;
    sti_data  = '0;
    sti_valid = 1'b0;
    checks    = 0;
    errors    = 0;
    rng       = 32'h2897bc71;
    m_cnt     = 0;
    m_sum     = 0;
    m_dec     = 0;
    m_shr     = 0;
    m_avg     = 1'b0;
    m_armed   = 1'b0;
    repeat (4) @(negedge bus);
    rst = 1'b0;
    regs_readback();
    decim_plain();
    decim_average();
    level_trigger();
    trigger_window();
    stop_and_reset();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(RUN_CYCLES * 2 * CLK_NS);
    $display("Simulation did not finish within its time limit");
    $display("Test failed");
    $finish;
  end

endmodule

/* all.f */
logic/osc_pkg.sv
logic/osc_regs.sv
logic/osc_decimator.sv
logic/osc_edge_trigger.sv
logic/osc_acquire.sv
logic/osc_top.sv
verif/osc_asserts.sv
verif/osc_tb.sv

/* Makefile */
# Verilator build and run for the oscilloscope channel testbench

VERILATOR ?= verilator
TOP       ?= osc_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
